// File: common/dma_pkg.sv
`default_nettype none

package dma_pkg;

    // Stream and bus widths
    localparam int sample_data_w = 20;
    localparam int dest_w        = 12;
    localparam int axi_data_w    = 64;
    localparam int axi_addr_w    = 49;
    localparam int axi_id_w      = 2;

    // AWSIZE encoding of a full 64-bit beat, also the byte shift of a beat index
    localparam int axi_size = 3;

    // Burst and FIFO sizing
    localparam int burst_len    = 4;
    localparam int fifo_depth   = 16;
    localparam int fifo_ptr_w   = $clog2(fifo_depth);
    localparam int fifo_count_w = $clog2(fifo_depth + 1);

    // Configuration port and register map
    localparam int reg_addr_w = 2;
    localparam int cfg_data_w = 32;

    localparam logic [reg_addr_w-1:0] reg_ctrl    = 2'd0;
    localparam logic [reg_addr_w-1:0] reg_base_lo = 2'd1;
    localparam logic [reg_addr_w-1:0] reg_base_hi = 2'd2;
    localparam logic [reg_addr_w-1:0] reg_status  = 2'd3;

    // One 32-bit memory word, the tag sits above the data
    typedef struct packed {
        logic [dest_w-1:0]        dest;
        logic [sample_data_w-1:0] data;
    } sample_t;

    // The odd sample of a pair goes to the upper word
    typedef struct packed {
        logic [axi_data_w-1:0] data;
        logic                  last;
    } beat_t;

    typedef struct packed {
        logic [axi_addr_w-1:0] addr;
        logic [7:0]            len;
        logic [axi_id_w-1:0]   id;
    } axi_aw_t;

    typedef struct packed {
        logic [axi_data_w-1:0]   data;
        logic [axi_data_w/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0]          resp;
        logic [axi_id_w-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic                  enable;
        logic [axi_addr_w-1:0] base_addr;
    } dma_cfg_t;

    // Read back as overflow in bit 16 and the packet count in bits 15:0
    typedef struct packed {
        logic        overflow;
        logic [15:0] packet_count;
    } dma_status_t;

endpackage

`default_nettype wire

// File: hdl/dma_regs.sv
`default_nettype none

module dma_regs (
    input  wire                                 axi_out,
    input  wire                                 reset,
    input  wire                                 cfg_write,
    input  wire [dma_pkg::reg_addr_w-1:0]       cfg_addr,
    input  wire [dma_pkg::cfg_data_w-1:0]       cfg_wdata,
    input  wire                                 packet_done,
    input  wire                                 drop,
    output logic [dma_pkg::cfg_data_w-1:0]      cfg_rdata,
    output dma_pkg::dma_cfg_t                   cfg
);
    import dma_pkg::*;

    dma_status_t status;

    always_ff @(posedge axi_out) begin
        if (reset) begin
            cfg.enable          <= 1'b0;
            cfg.base_addr       <= '0;
            status.packet_count <= '0;
            status.overflow     <= 1'b0;
        end else begin
            if (cfg_write) begin
                case (cfg_addr)
                    reg_ctrl:    cfg.enable <= cfg_wdata[0];
                    reg_base_lo: cfg.base_addr[cfg_data_w-1:0] <= cfg_wdata;
                    reg_base_hi: begin
                        cfg.base_addr[axi_addr_w-1:cfg_data_w] <=
                            cfg_wdata[axi_addr_w-cfg_data_w-1:0];
                    end
                    default: ;
                endcase
            end

            if (packet_done) begin
                status.packet_count <= status.packet_count + 16'd1;
            end

            // A new drop wins over a clearing write in the same cycle
            if (drop) begin
                status.overflow <= 1'b1;
            end else if (cfg_write && cfg_addr == reg_status) begin
                status.overflow <= 1'b0;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            reg_ctrl:    cfg_rdata = cfg_data_w'(cfg.enable);
            reg_base_lo: cfg_rdata = cfg.base_addr[cfg_data_w-1:0];
            reg_base_hi: cfg_rdata = cfg_data_w'(cfg.base_addr[axi_addr_w-1:cfg_data_w]);
            default:     cfg_rdata = cfg_data_w'(status);
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/sample_packer.sv
`default_nettype none

module sample_packer (
    input  wire                    axi_out,
    input  wire                    reset,
    input  wire                    enable,
    input  wire dma_pkg::sample_t  sample_in,
    input  wire                    in_valid,
    input  wire                    in_last,
    input  wire                    fifo_full,
    output logic                   push,
    output dma_pkg::beat_t         push_beat,
    output logic                   drop
);
    import dma_pkg::*;

    sample_t pending;
    logic    pending_valid;
    beat_t   beat_q;
    logic    beat_ready;

    // Pairing control, a partial pair is thrown away while disabled
    always_ff @(posedge axi_out) begin
        if (reset) begin
            pending_valid <= 1'b0;
            beat_ready    <= 1'b0;
        end else begin
            beat_ready <= 1'b0;
            if (!enable) begin
                pending_valid <= 1'b0;
            end else if (in_valid) begin
                if (pending_valid) begin
                    beat_ready    <= 1'b1;
                    pending_valid <= 1'b0;
                end else if (in_last) begin
                    beat_ready <= 1'b1;
                end else begin
                    pending_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axi_out) begin
        if (enable && in_valid) begin
            if (pending_valid) begin
                beat_q.data <= {sample_in, pending};
                beat_q.last <= in_last;
            end else if (in_last) begin
                // Lone closing sample, upper word padded with zeros
                beat_q.data <= {{$bits(sample_t){1'b0}}, sample_in};
                beat_q.last <= 1'b1;
            end else begin
                pending <= sample_in;
            end
        end
    end

    // The FIFO state is checked on the cycle the beat is offered
    assign push      = beat_ready && !fifo_full;
    assign drop      = beat_ready && fifo_full;
    assign push_beat = beat_q;

endmodule

`default_nettype wire

// File: hdl/beat_fifo.sv
`default_nettype none

module beat_fifo #(
    parameter type payload_t = dma_pkg::beat_t
) (
    input  wire                                 axi_out,
    input  wire                                 reset,
    input  wire                                 push,
    input  wire payload_t                       push_data,
    input  wire                                 pop,
    output payload_t                            head,
    output logic [dma_pkg::fifo_count_w-1:0]    count,
    output logic                                full,
    output logic [dma_pkg::burst_len-1:0]       last_mask
);
    import dma_pkg::*;

    payload_t              mem [fifo_depth];
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic                  wr_en;
    logic                  rd_en;

    assign full  = (count == fifo_count_w'(fifo_depth));
    assign wr_en = push && !full;
    assign rd_en = pop && (count != '0);

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge axi_out) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge axi_out) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign head = mem[rd_ptr];

    // Last flags of the entries a single burst could reach, empty slots read as 0
    always_comb begin
        for (int i = 0; i < burst_len; i++) begin
            last_mask[i] = (fifo_count_w'(i) < count) && mem[rd_ptr + fifo_ptr_w'(i)].last;
        end
    end

endmodule

`default_nettype wire

// File: axi_writer/axi_burst_writer.sv
`default_nettype none

module axi_burst_writer (
    input  wire                                 axi_out,
    input  wire                                 reset,
    input  wire [dma_pkg::axi_addr_w-1:0]       base_addr,
    input  wire [dma_pkg::fifo_count_w-1:0]     count,
    input  wire [dma_pkg::burst_len-1:0]        last_mask,
    input  wire dma_pkg::beat_t                 head,
    input  wire                                 aw_ready,
    input  wire                                 w_ready,
    input  wire dma_pkg::axi_b_t                b,
    input  wire                                 b_valid,
    output logic                                pop,
    output dma_pkg::axi_aw_t                    aw,
    output logic                                aw_valid,
    output dma_pkg::axi_w_t                     w,
    output logic                                w_valid,
    output logic                                b_ready,
    output logic                                packet_done
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_address,
        st_data,
        st_response
    } state_t;

    state_t                         state;
    logic [axi_addr_w-axi_size-1:0] beat_offset;
    logic [7:0]                     beats_left;
    logic [7:0]                     burst_beats;
    logic                           closes_packet;
    logic                           found_last;
    logic                           start;
    logic                           b_hit;

    // Size the next burst: up to the first packet end, else a full burst
    always_comb begin
        found_last  = 1'b0;
        burst_beats = 8'(burst_len);
        for (int i = burst_len - 1; i >= 0; i--) begin
            if (last_mask[i]) begin
                found_last  = 1'b1;
                burst_beats = 8'(i + 1);
            end
        end
        start = found_last || (count >= fifo_count_w'(burst_len));
    end

    assign b_hit = b_valid && (b.id == aw.id);

    always_ff @(posedge axi_out) begin
        if (reset) begin
            state       <= st_idle;
            aw_valid    <= 1'b0;
            packet_done <= 1'b0;
            beat_offset <= '0;
        end else begin
            packet_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        aw_valid <= 1'b1;
                        state    <= st_address;
                    end
                end
                st_address: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        state    <= st_data;
                    end
                end
                st_data: begin
                    if (w_ready) begin
                        beat_offset <= beat_offset + 1'b1;
                        if (beats_left == 8'd0) begin
                            state <= st_response;
                        end
                    end
                end
                st_response: begin
                    if (b_hit) begin
                        state <= st_idle;
                        // The next packet starts over at the base address
                        if (closes_packet) begin
                            packet_done <= 1'b1;
                            beat_offset <= '0;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address channel payload is captured at the decision and held until accepted
    always_ff @(posedge axi_out) begin
        if (state == st_idle && start) begin
            aw.addr       <= base_addr + {beat_offset, axi_size'(0)};
            aw.len        <= burst_beats - 8'd1;
            aw.id         <= '0;
            closes_packet <= found_last;
            beats_left    <= burst_beats - 8'd1;
        end else if (pop) begin
            beats_left <= beats_left - 8'd1;
        end
    end

    // W beats come straight from the FIFO head
    assign w_valid = (state == st_data);
    assign w.data  = head.data;
    assign w.strb  = '1;
    assign w.last  = (beats_left == 8'd0);
    assign pop     = w_valid && w_ready;
    assign b_ready = 1'b1;

endmodule

`default_nettype wire

// File: hdl/axi_dma.sv
`default_nettype none

module axi_dma (
    input  wire                                 axi_out,
    input  wire                                 reset,
    input  wire dma_pkg::sample_t               sample_in,
    input  wire                                 in_valid,
    input  wire                                 in_last,
    input  wire                                 cfg_write,
    input  wire [dma_pkg::reg_addr_w-1:0]       cfg_addr,
    input  wire [dma_pkg::cfg_data_w-1:0]       cfg_wdata,
    input  wire                                 aw_ready,
    input  wire                                 w_ready,
    input  wire dma_pkg::axi_b_t                b,
    input  wire                                 b_valid,
    output logic [dma_pkg::cfg_data_w-1:0]      cfg_rdata,
    output dma_pkg::axi_aw_t                    aw,
    output logic                                aw_valid,
    output dma_pkg::axi_w_t                     w,
    output logic                                w_valid,
    output logic                                b_ready,
    output logic                                dma_done
);
    import dma_pkg::*;

    dma_cfg_t                cfg;
    beat_t                   push_beat;
    beat_t                   head;
    logic                    push;
    logic                    pop;
    logic                    drop;
    logic                    full;
    logic [fifo_count_w-1:0] count;
    logic [burst_len-1:0]    last_mask;

    dma_regs regs (
        .axi_out     (axi_out),
        .reset       (reset),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .packet_done (dma_done),
        .drop        (drop),
        .cfg_rdata   (cfg_rdata),
        .cfg         (cfg)
    );

    sample_packer packer (
        .axi_out   (axi_out),
        .reset     (reset),
        .enable    (cfg.enable),
        .sample_in (sample_in),
        .in_valid  (in_valid),
        .in_last   (in_last),
        .fifo_full (full),
        .push      (push),
        .push_beat (push_beat),
        .drop      (drop)
    );

    beat_fifo #(
        .payload_t (beat_t)
    ) fifo (
        .axi_out   (axi_out),
        .reset     (reset),
        .push      (push),
        .push_data (push_beat),
        .pop       (pop),
        .head      (head),
        .count     (count),
        .full      (full),
        .last_mask (last_mask)
    );

    axi_burst_writer writer (
        .axi_out     (axi_out),
        .reset       (reset),
        .base_addr   (cfg.base_addr),
        .count       (count),
        .last_mask   (last_mask),
        .head        (head),
        .aw_ready    (aw_ready),
        .w_ready     (w_ready),
        .b           (b),
        .b_valid     (b_valid),
        .pop         (pop),
        .aw          (aw),
        .aw_valid    (aw_valid),
        .w           (w),
        .w_valid     (w_valid),
        .b_ready     (b_ready),
        .packet_done (dma_done)
    );

endmodule

`default_nettype wire

// File: testbench/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
    input  wire                  axi_out,
    input  wire                  reset,
    input  wire                  clear,
    input  wire [1:0]            stall_mode,
    input  wire dma_pkg::axi_aw_t aw,
    input  wire                  aw_valid,
    output logic                 aw_ready,
    input  wire dma_pkg::axi_w_t w,
    input  wire                  w_valid,
    output logic                 w_ready,
    output dma_pkg::axi_b_t      b,
    output logic                 b_valid,
    input  wire                  b_ready
);
    timeunit 1ns;
    timeprecision 100ps;
    import dma_pkg::*;

    // Memory window of 256 beats, indexed by address bits 10:3
    logic [63:0]           words [256];
    logic [axi_addr_w-1:0] aw_addrs [64];
    logic [7:0]            aw_lens [64];
    logic [axi_addr_w-1:0] cur_addr;
    logic [axi_id_w-1:0]   cur_id;
    logic [7:0]            cur_len;
    logic [7:0]            beat_idx;
    logic [31:0]           lfsr;
    logic                  outstanding;
    logic                  b_pending;
    logic                  b_delay;
    logic                  stall_armed;
    int                    stall_cnt;
    int                    aw_count;
    int                    w_count;
    int                    proto_errors;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Outputs stay low until the first clock edge in reset
    initial begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b        = '0;
    end

    // Outputs to the DUT change 1 ns after the clock edge
    always @(posedge axi_out) begin : slave
        logic [31:0] s;
        logic [3:0]  bits;
        s = lfsr;
        for (int i = 0; i < 4; i++) begin
            s = lfsr_step(s);
            bits[i] = s[0];
        end
        if (reset) begin
            lfsr         <= 32'habeb_84ed;
            aw_ready     <= #1 1'b0;
            w_ready      <= #1 1'b0;
            b_valid      <= #1 1'b0;
            b            <= #1 '0;
            outstanding  <= 1'b0;
            b_pending    <= 1'b0;
            b_delay      <= 1'b0;
            stall_armed  <= 1'b0;
            stall_cnt    <= 0;
            aw_count     <= 0;
            w_count      <= 0;
            proto_errors <= 0;
        end else begin
            lfsr     <= s;
            aw_ready <= #1 (stall_mode != 2'd1) || !(bits[0] && bits[1]);

            // Mode 2 holds w_ready low for 40 cycles after the first AW of a packet
            if (aw_valid && aw_ready && stall_armed) begin
                stall_cnt   <= 39;
                stall_armed <= 1'b0;
                w_ready     <= #1 1'b0;
            end else if (stall_cnt != 0) begin
                stall_cnt <= stall_cnt - 1;
                w_ready   <= #1 1'b0;
            end else begin
                w_ready <= #1 (stall_mode != 2'd1) || !(bits[2] && bits[3]);
            end

            if (clear) begin
                aw_count    <= 0;
                w_count     <= 0;
                stall_armed <= (stall_mode == 2'd2);
                for (int i = 0; i < 256; i++) begin
                    words[i] <= '0;
                end
            end else begin
                if (aw_valid && aw_ready) begin
                    if (outstanding) begin
                        proto_errors <= proto_errors + 1;
                    end
                    outstanding <= 1'b1;
                    cur_addr    <= aw.addr;
                    cur_id      <= aw.id;
                    cur_len     <= aw.len;
                    beat_idx    <= '0;
                    if (aw_count < 64) begin
                        aw_addrs[aw_count] <= aw.addr;
                        aw_lens[aw_count]  <= aw.len;
                    end
                    aw_count <= aw_count + 1;
                end
                if (w_valid && w_ready) begin
                    if (w.last != (beat_idx == cur_len) || w.strb != 8'hff) begin
                        proto_errors <= proto_errors + 1;
                    end
                    words[cur_addr[10:3]] <= w.data;
                    cur_addr <= cur_addr + 49'd8;
                    beat_idx <= beat_idx + 8'd1;
                    w_count  <= w_count + 1;
                    if (beat_idx == cur_len) begin
                        b_pending <= 1'b1;
                        b_delay   <= 1'b1;
                    end
                end
            end

            if (b_pending) begin
                if (b_delay) begin
                    b_delay <= 1'b0;
                end else begin
                    b_valid   <= #1 1'b1;
                    b         <= #1 '{resp: 2'b00, id: cur_id};
                    b_pending <= 1'b0;
                end
            end
            if (b_valid && b_ready) begin
                b_valid     <= #1 1'b0;
                outstanding <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/axi_dma_tb.sv
`default_nettype none

module axi_dma_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dma_pkg::*;

    localparam int max_tests = 32;

    logic                  axi_out;
    logic                  reset;
    sample_t               sample_in;
    logic                  in_valid;
    logic                  in_last;
    logic                  cfg_write;
    logic [reg_addr_w-1:0] cfg_addr;
    logic [cfg_data_w-1:0] cfg_wdata;
    logic [cfg_data_w-1:0] cfg_rdata;
    axi_aw_t               aw;
    logic                  aw_valid;
    logic                  aw_ready;
    axi_w_t                w;
    logic                  w_valid;
    logic                  w_ready;
    axi_b_t                b;
    logic                  b_valid;
    logic                  b_ready;
    logic                  dma_done;
    logic                  mem_clear;
    logic [1:0]            stall_mode;

    logic [axi_addr_w-1:0] t_base [max_tests];
    int                    t_len [max_tests];
    logic [19:0]           t_data [max_tests];
    logic [11:0]           t_dest [max_tests];
    logic                  t_enable [max_tests];
    logic [1:0]            t_stall [max_tests];
    int                    num_tests;
    int                    errors;
    int                    done_count;
    int                    done_beats;
    int                    completed;
    int                    limit_cycles;
    logic                  loaded;

    axi_dma uut (
        .axi_out(axi_out), .reset(reset), .sample_in(sample_in), .in_valid(in_valid),
        .in_last(in_last), .cfg_write(cfg_write), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .aw_ready(aw_ready), .w_ready(w_ready), .b(b),
        .b_valid(b_valid), .cfg_rdata(cfg_rdata), .aw(aw), .aw_valid(aw_valid),
        .w(w), .w_valid(w_valid), .b_ready(b_ready), .dma_done(dma_done)
    );

    axi_mem_model mem (
        .axi_out(axi_out), .reset(reset), .clear(mem_clear), .stall_mode(stall_mode),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready), .w(w), .w_valid(w_valid),
        .w_ready(w_ready), .b(b), .b_valid(b_valid), .b_ready(b_ready)
    );

    always #5 axi_out = ~axi_out;

    // Also notes how many beats the memory had taken when dma_done pulsed
    always @(posedge axi_out) begin
        if (!reset && dma_done) begin
            done_count++;
            done_beats = mem.w_count;
        end
    end

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge axi_out);
        #1;
    endtask

    task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [31:0] data);
        step();
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_write = 1'b0;
    endtask

    task automatic read_reg(input logic [reg_addr_w-1:0] addr, output logic [31:0] data);
        step();
        cfg_addr = addr;
        #2;
        data = cfg_rdata;
    endtask

    // Sample n of test i, with the tag above the data
    function automatic logic [31:0] sample_word(input int i, input int n);
        logic [11:0] d;
        logic [19:0] v;
        d = t_dest[i] + 12'(n);
        v = t_data[i] + 20'(n);
        return {d, v};
    endfunction

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [48:0] base;
        int          len;
        logic [19:0] d;
        logic [11:0] t;
        int          en;
        int          st;
        fd = $fopen("testbench/dma_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the pattern file could not be opened");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %d %h %h %d %d", base, len, d, t, en, st);
            if (n == 6 && num_tests < max_tests) begin
                t_base[num_tests]   = base;
                t_len[num_tests]    = len;
                t_data[num_tests]   = d;
                t_dest[num_tests]   = t;
                t_enable[num_tests] = (en != 0);
                t_stall[num_tests]  = 2'(st);
                num_tests++;
            end
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("ERROR: the pattern file holds no tests");
            errors++;
        end
    endtask

    task automatic send_packet(input int i, input int gap);
        for (int n = 0; n < t_len[i]; n++) begin
            step();
            sample_in = sample_word(i, n);
            in_valid  = 1'b1;
            in_last   = (n == t_len[i] - 1);
            if (gap > 0) begin
                step();
                in_valid = 1'b0;
                in_last  = 1'b0;
                repeat (gap - 1) step();
            end
        end
        step();
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic check_memory(input int i);
        int          nb;
        int          bursts;
        int          idx;
        logic [31:0] upper;
        nb     = (t_len[i] + 1) / 2;
        bursts = (nb + burst_len - 1) / burst_len;
        check("beats written", mem.w_count, nb);
        check("aw count", mem.aw_count, bursts);
        for (int k = 0; k < bursts && k < 64; k++) begin
            check("aw addr", mem.aw_addrs[k], t_base[i] + 49'(8 * burst_len * k));
            check("aw len", mem.aw_lens[k],
                  (k == bursts - 1) ? nb - burst_len * k - 1 : burst_len - 1);
        end
        for (int k = 0; k < nb; k++) begin
            idx   = ((t_base[i] >> 3) + k) & 255;
            upper = (2 * k + 1 < t_len[i]) ? sample_word(i, 2 * k + 1) : 32'h0;
            check("memory word", mem.words[idx], {upper, sample_word(i, 2 * k)});
        end
    endtask

    task automatic run_test(input int i);
        int          waited;
        logic [31:0] rd;
        stall_mode = t_stall[i];
        write_reg(reg_base_lo, t_base[i][31:0]);
        write_reg(reg_base_hi, 32'(t_base[i][48:32]));
        write_reg(reg_ctrl, 32'(t_enable[i]));
        step();
        mem_clear = 1'b1;
        step();
        mem_clear = 1'b0;
        // Back-to-back samples only where the FIFO is meant to overflow
        send_packet(i, (t_stall[i] == 2'd2) ? 0 : 3);
        if (!t_enable[i]) begin
            repeat (60) step();
            check("dma_done count", done_count, completed);
            check("aw count", mem.aw_count, 0);
            return;
        end
        waited = 0;
        while (done_count <= completed && waited < t_len[i] * 20 + 500) begin
            step();
            waited++;
        end
        if (done_count <= completed) begin
            $display("ERROR: dma_done never arrived for test %0d", i);
            errors++;
        end
        completed++;
        repeat (30) step();
        check("dma_done count", done_count, completed);
        check("beats before dma_done", done_beats, mem.w_count);
        check("protocol errors", mem.proto_errors, 0);
        read_reg(reg_status, rd);
        check("status.packet_count", rd[15:0], completed);
        check("status.overflow", rd[16], t_stall[i] == 2'd2);
        if (t_stall[i] == 2'd2) begin
            write_reg(reg_status, 32'h0);
            read_reg(reg_status, rd);
            check("status.overflow", rd[16], 1'b0);
        end else begin
            check_memory(i);
        end
    endtask

    initial begin
        axi_out    = 1'b0;
        reset      = 1'b1;
        sample_in  = '0;
        in_valid   = 1'b0;
        in_last    = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        mem_clear  = 1'b0;
        stall_mode = 2'd0;
        num_tests  = 0;
        errors     = 0;
        done_count = 0;
        done_beats = 0;
        completed  = 0;
        loaded     = 1'b0;
        load_patterns();
        limit_cycles = 2000;
        for (int i = 0; i < num_tests; i++) begin
            limit_cycles += t_len[i] * 20;
        end
        loaded = 1'b1;
        repeat (4) @(posedge axi_out);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end
        repeat (10) step();
        $display("Checks finished over %0d tests with %0d errors", num_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge axi_out);
        $display("ERROR: watchdog expired after %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/dma_patterns.txt
# base_addr (hex)  length (dec)  first_data (hex)  dest (hex)  enable  stall_mode
# stall_mode 0 ready high, 1 LFSR ready stalls, 2 w_ready held low for 40 cycles
0000000001000  8   00010  0a1  1  0
0000000001100  7   fffff  ffe  1  0
0000000001200  1   12345  123  1  0
0000000001300  2   00001  001  1  0
0000000001400  16  0abcd  7f0  1  1
0000000001500  9   80000  800  1  1
1f00000001600  13  54321  fff  1  1
0000000001700  10  11111  222  0  0
0000000001700  4   22222  333  1  0
0000000001000  5   33333  444  1  1
0000000001000  64  44444  555  1  2
0000000001800  3   55555  666  1  0
0000000001000  31  66666  010  1  1
0000000003f00  11  77777  abc  1  0
0000000002000  64  fffc0  f00  1  1
0000000002400  6   00000  000  1  0

// File: tb.f
common/dma_pkg.sv
hdl/dma_regs.sv
hdl/sample_packer.sv
hdl/beat_fifo.sv
axi_writer/axi_burst_writer.sv
hdl/axi_dma.sv
testbench/axi_mem_model.sv
testbench/axi_dma_tb.sv
